//--- Makefile
# Verilator flow for cart_tb, run from the project root

.PHONY: all run lint clean

all: run

obj_dir/Vcart_tb: src.f $(wildcard design/*.sv) tb/cart_tb.sv
	verilator --binary --timing -f src.f --top-module cart_tb -Mdir obj_dir -o Vcart_tb

# pass only if the testbench printed its pass line
run: obj_dir/Vcart_tb
	./obj_dir/Vcart_tb | tee /dev/stderr | grep -x "PASS: all tests" > /dev/null

lint:
	verilator --lint-only --timing -f src.f --top-module cart_top

clean:
	rm -rf obj_dir

//--- design/bus_read_mux.sv
/*
 Merges the port responses by OR and drives the slot data bus.
 Read latency from the strobe is 2 cycles. out_enable is sampled when
 the read data arrives, not while the bus is driven.
*/
`timescale 1ns/100ps

module bus_read_mux (
	input  logic               clk,
	input  logic               w_n_reset,
	input  cart_pkg::bus_req_t bus_req,
	input  cart_pkg::bus_rsp_t rsp_io,
	input  cart_pkg::bus_rsp_t rsp_mem,
	input  logic               out_enable,
	output logic               bus_claim,
	output logic [7:0]         read_data,
	output logic               data_oe
);

	cart_pkg::bus_rsp_t merged;
	logic [7:0]         ff_read_data;
	logic               ff_data_oe;

	// ports answer zero when idle
	assign merged    = rsp_io | rsp_mem;
	assign bus_claim = merged.claim;

	// ------------------------------
	// data latch and bus drive
	// ------------------------------
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			ff_read_data <= 8'h00;
			ff_data_oe   <= 1'b0;
		end else begin
			if (merged.read_ready) begin
				ff_read_data <= merged.read_data;
			end
			// drive only when switch 7 allows it
			if (merged.read_ready) begin
				ff_data_oe <= out_enable;
			end else if (!bus_req.read) begin
				// release once the read level is gone
				ff_data_oe <= 1'b0;
			end
		end
	end

	assign read_data = ff_read_data;
	assign data_oe   = ff_data_oe;

endmodule

//--- design/cart_pkg.sv
/*
 Shared types and constants for the MSX cartridge core.
 Tone timing assumes a 64 MHz clk, so one sound tick is about 1 us.
*/
package cart_pkg;

	// ------------------------------
	// bus types
	// ------------------------------

	// request from the slot, levels held for the whole access
	typedef struct packed {
		logic [15:0] address;
		logic [7:0]  write_data;
		logic        read;
		logic        write;
		logic        io;
		logic        memory;
	} bus_req_t;

	// one port's answer, read_data is zero outside read_ready
	typedef struct packed {
		logic       claim;
		logic       read_ready;
		logic [7:0] read_data;
	} bus_rsp_t;

	typedef logic [7:0]  io_addr_t;
	typedef logic [15:0] mem_addr_t;

	// ------------------------------
	// port addresses
	// ------------------------------
	localparam io_addr_t  GPIO_IO_ADDR  = 8'h01;
	localparam mem_addr_t GPIO_MEM_ADDR = 16'h8001;

	// ------------------------------
	// tone timing
	// ------------------------------

	// clk cycles per sound tick
	localparam logic [6:0] TICK_CYCLES = 7'd64;
	// ticks per note, about 100 ms
	localparam logic [16:0] NOTE_TICKS_DEFAULT = 17'd100000;
	localparam int NOTE_COUNT = 8;

	// half-period in ticks, C4 up to C5
	localparam logic [0:NOTE_COUNT-1][15:0] NOTE_DIV = '{
		16'd1911,
		16'd1702,
		16'd1516,
		16'd1431,
		16'd1275,
		16'd1136,
		16'd1012,
		16'd955
	};

	// loudness per note, falling
	localparam logic [0:NOTE_COUNT-1][7:0] NOTE_LEVEL = '{
		8'hFF,
		8'hCC,
		8'hAA,
		8'h88,
		8'h66,
		8'h44,
		8'h22,
		8'h0B
	};

	// amplitude until the first note change
	localparam logic [7:0] RESET_LEVEL = 8'hFF;

endpackage

//--- design/cart_top.sv
/*
 Bus-side cartridge core: io port at 01h, memory port at 8001h and a
 test tone. The memory port decodes on the memory flag alone, there
 is no sub-slot select. w_n_reset must already be synchronous to clk.
*/
`timescale 1ns/100ps

module cart_top #(
	parameter logic [16:0] NOTE_TICKS = cart_pkg::NOTE_TICKS_DEFAULT
) (
	input  logic               clk,
	input  logic               w_n_reset,
	input  cart_pkg::bus_req_t bus_req,
	input  logic [7:0]         dip_sw,
	output logic               bus_claim,
	output logic [7:0]         read_data,
	output logic               data_oe,
	output logic [5:0]         n_led,
	output logic [7:0]         io_gpo,
	output logic               sound
);

	cart_pkg::bus_rsp_t rsp_io;
	cart_pkg::bus_rsp_t rsp_mem;
	logic [7:0]         mem_gpo;
	logic               tick;
	logic [7:0]         sample;

	// ------------------------------
	// general-purpose ports
	// ------------------------------

	// io port, dip switches on read
	gpio_port #(
		.addr_t (cart_pkg::io_addr_t),
		.BASE   (cart_pkg::GPIO_IO_ADDR),
		.IS_IO  (1'b1)
	) io_port_i (
		.clk       (clk),
		.w_n_reset (w_n_reset),
		.bus_req   (bus_req),
		.gpi       (dip_sw),
		.rsp       (rsp_io),
		.gpo       (io_gpo)
	);

	// memory port, low six bits go to the leds
	gpio_port #(
		.addr_t (cart_pkg::mem_addr_t),
		.BASE   (cart_pkg::GPIO_MEM_ADDR),
		.IS_IO  (1'b0)
	) mem_port_i (
		.clk       (clk),
		.w_n_reset (w_n_reset),
		.bus_req   (bus_req),
		.gpi       (dip_sw),
		.rsp       (rsp_mem),
		.gpo       (mem_gpo)
	);

	assign n_led = mem_gpo[5:0];

	// switch 7 enables the data bus drive
	bus_read_mux bus_read_mux_i (
		.clk        (clk),
		.w_n_reset  (w_n_reset),
		.bus_req    (bus_req),
		.rsp_io     (rsp_io),
		.rsp_mem    (rsp_mem),
		.out_enable (dip_sw[7]),
		.bus_claim  (bus_claim),
		.read_data  (read_data),
		.data_oe    (data_oe)
	);

	// ------------------------------
	// sound path
	// ------------------------------
	tone_sequencer #(
		.NOTE_TICKS (NOTE_TICKS)
	) tone_sequencer_i (
		.clk       (clk),
		.w_n_reset (w_n_reset),
		.tick      (tick),
		.sample    (sample)
	);

	pwm_dac pwm_dac_i (
		.clk       (clk),
		.w_n_reset (w_n_reset),
		.tick      (tick),
		.sample    (sample),
		.sound     (sound)
	);

endmodule

//--- design/gpio_port.sv
/*
 Address-matched 8-bit port. Accesses are detected on the rising edge
 of read or write, so a held strobe acts once. Read data is zero
 outside the read_ready pulse, responses may be merged by OR.
*/
`timescale 1ns/100ps

module gpio_port #(
	parameter type addr_t = logic [7:0],
	parameter addr_t BASE = '0,
	parameter bit IS_IO = 1'b1
) (
	input  logic               clk,
	input  logic               w_n_reset,
	input  cart_pkg::bus_req_t bus_req,
	input  logic [7:0]         gpi,
	output cart_pkg::bus_rsp_t rsp,
	output logic [7:0]         gpo
);

	localparam int ADDR_W = $bits(addr_t);

	logic       addr_match;
	logic       space_match;
	logic       claim;
	logic       ff_read_d;
	logic       ff_write_d;
	logic       read_edge;
	logic       write_edge;
	logic       ff_read_ready;
	logic [7:0] ff_read_data;
	logic [7:0] ff_gpo;

	// ------------------------------
	// address decode
	// ------------------------------

	// only the low bits count, an io address is 8 bits wide
	assign addr_match  = (addr_t'(bus_req.address[ADDR_W-1:0]) == BASE);
	assign space_match = IS_IO ? bus_req.io : bus_req.memory;
	assign claim       = addr_match & space_match;

	// ------------------------------
	// strobe edges
	// ------------------------------

	// previous strobe levels
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			ff_read_d  <= 1'b0;
			ff_write_d <= 1'b0;
		end else begin
			ff_read_d  <= bus_req.read;
			ff_write_d <= bus_req.write;
		end
	end

	assign read_edge  = claim & bus_req.read & ~ff_read_d;
	assign write_edge = claim & bus_req.write & ~ff_write_d;

	// output byte and read pulse
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			ff_gpo        <= 8'h00;
			ff_read_ready <= 1'b0;
		end else begin
			if (write_edge) begin
				ff_gpo <= bus_req.write_data;
			end
			ff_read_ready <= read_edge;
		end
	end

	// sampled input, only seen through read_ready
	always_ff @(posedge clk) begin
		ff_read_data <= gpi;
	end

	assign rsp = '{
		claim:      claim,
		read_ready: ff_read_ready,
		read_data:  ff_read_ready ? ff_read_data : 8'h00
	};
	assign gpo = ff_gpo;

endmodule

//--- design/pwm_dac.sv
/*
 First-order sigma-delta DAC, one step per tick. Density of ones in
 sound is sample/256, an external RC filter is assumed.
*/
`timescale 1ns/100ps

module pwm_dac (
	input  logic       clk,
	input  logic       w_n_reset,
	input  logic       tick,
	input  logic [7:0] sample,
	output logic       sound
);

	logic [7:0] ff_acc;
	logic       ff_sound;
	logic [8:0] acc_sum;

	// carry out is the next sound bit
	assign acc_sum = {1'b0, ff_acc} + {1'b0, sample};

	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			ff_acc   <= 8'h00;
			ff_sound <= 1'b0;
		end else if (tick) begin
			ff_acc   <= acc_sum[7:0];
			ff_sound <= acc_sum[8];
		end
	end

	assign sound = ff_sound;

endmodule

//--- design/tone_sequencer.sv
/*
 Test tone: eight notes C4 to C5, each held NOTE_TICKS ticks, with
 falling loudness. The first note change comes NOTE_TICKS ticks after
 reset, until then the divider is zero and the tone runs at tick rate.
*/
`timescale 1ns/100ps

module tone_sequencer #(
	parameter logic [16:0] NOTE_TICKS = cart_pkg::NOTE_TICKS_DEFAULT
) (
	input  logic       clk,
	input  logic       w_n_reset,
	output logic       tick,
	output logic [7:0] sample
);

	localparam int IDX_W = $clog2(cart_pkg::NOTE_COUNT);
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(cart_pkg::NOTE_COUNT - 1);

	logic [6:0]       ff_tick_count;
	logic [15:0]      ff_div_count;
	logic [15:0]      ff_half_period;
	logic [7:0]       ff_level;
	logic [7:0]       ff_sample;
	logic [16:0]      ff_note_count;
	logic [IDX_W-1:0] ff_note_idx;
	logic             div_flip;
	logic             note_change;

	// ------------------------------
	// tick prescaler
	// ------------------------------

	// zero after reset, so the first tick is immediate
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			ff_tick_count <= 7'd0;
		end else if (tick) begin
			ff_tick_count <= cart_pkg::TICK_CYCLES - 7'd1;
		end else begin
			ff_tick_count <= ff_tick_count - 7'd1;
		end
	end

	assign tick = (ff_tick_count == 7'd0);

	// ------------------------------
	// square wave
	// ------------------------------
	assign div_flip = (ff_div_count == 16'd0);

	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			ff_div_count <= 16'd0;
			ff_sample    <= 8'h00;
		end else if (tick) begin
			if (div_flip) begin
				// reload from the period in use now
				ff_div_count <= ff_half_period;
				// toggle between silence and amplitude
				if (ff_sample != 8'h00) begin
					ff_sample <= 8'h00;
				end else begin
					ff_sample <= ff_level;
				end
			end else begin
				ff_div_count <= ff_div_count - 16'd1;
			end
		end
	end

	// ------------------------------
	// note stepping
	// ------------------------------
	assign note_change = (ff_note_count == 17'd0);

	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			ff_note_count <= NOTE_TICKS;
			ff_note_idx   <= '0;
		end else if (tick) begin
			if (note_change) begin
				ff_note_count <= NOTE_TICKS;
				// wrap after the top C
				if (ff_note_idx == LAST_IDX) begin
					ff_note_idx <= '0;
				end else begin
					ff_note_idx <= ff_note_idx + 1'b1;
				end
			end else begin
				ff_note_count <= ff_note_count - 17'd1;
			end
		end
	end

	// table lookup at the index before it steps
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			ff_half_period <= 16'd0;
			ff_level       <= cart_pkg::RESET_LEVEL;
		end else if (tick && note_change) begin
			ff_half_period <= cart_pkg::NOTE_DIV[ff_note_idx];
			ff_level       <= cart_pkg::NOTE_LEVEL[ff_note_idx];
		end
	end

	assign sample = ff_sample;

endmodule

//--- src.f
design/cart_pkg.sv
design/gpio_port.sv
design/bus_read_mux.sv
design/tone_sequencer.sv
design/pwm_dac.sv
design/cart_top.sv
tb/cart_tb.sv

//--- tb/bus_test_input.txt
# op W or R, space I (io) or M (memory), address, data, dip_sw; all hex
# data is the byte written, or the bus value expected from a driven read
W I 01 5A 00
W I 02 33 00
W I 00 77 00
W I 01 A5 00
W I FF 11 00
W M 8001 2B 00
W M 0001 3F 00
W I 01 C4 00
W M 8000 15 00
W M 8001 FF 00
W M 8011 00 00
W M C001 01 00
W M 8001 15 00
W I 01 00 00
R I 01 C3 C3
R M 8001 9E 9E
R I 01 FF FF
R M 8001 80 80
R I 01 A7 A7
R M 8001 EA EA
R I 01 00 7F
R M 8001 00 3C
R I 01 00 00
R I 02 00 80
R I 10 00 FF
R M 8000 00 FF
R M 0001 00 80
R M 8101 00 80
W I 01 3C 80
R I 01 81 81
W M 8001 2A 80
R M 8001 F0 F0
R I 01 00 7E
R M 8001 C0 C0

//--- tb/cart_tb.sv
/*
 Testbench for cart_top. Bus accesses and expected bytes come from
 tb/bus_test_input.txt. NOTE_TICKS is cut to 20 so the first note
 change falls inside the 40-tick sound window.
*/
`timescale 1ns/100ps

module cart_tb;

	// one access line of the input file
	typedef struct packed {
		logic [7:0]  op;
		logic [7:0]  space;
		logic [15:0] address;
		logic [7:0]  data;
		logic [7:0]  dip;
	} access_t;

	logic               clk = 1'b0;
	logic               w_n_reset;
	cart_pkg::bus_req_t bus_req;
	logic [7:0]         dip_sw;
	logic               bus_claim;
	logic [7:0]         read_data;
	logic               data_oe;
	logic [5:0]         n_led;
	logic [7:0]         io_gpo;
	logic               sound;

	access_t    accesses[$];
	int         cycle_count = 0;
	int         timeout_limit = 3000;
	// output bytes as the accesses so far should have left them
	logic [7:0] exp_io_gpo;
	logic [5:0] exp_n_led;

	// short notes, 20 ticks each
	cart_top #(
		.NOTE_TICKS (17'd20)
	) cart_top_i (
		.clk       (clk),
		.w_n_reset (w_n_reset),
		.bus_req   (bus_req),
		.dip_sw    (dip_sw),
		.bus_claim (bus_claim),
		.read_data (read_data),
		.data_oe   (data_oe),
		.n_led     (n_led),
		.io_gpo    (io_gpo),
		.sound     (sound)
	);

	// 4 ns period
	always #2 clk = ~clk;

	// ------------------------------
	// run limit
	// ------------------------------
	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= timeout_limit) begin
			$display("timeout: run did not finish within %0d cycles", timeout_limit);
			abort_run();
		end
	end

	task automatic abort_run();
		$display("FAIL: see errors above");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_equal(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("[FAIL] t=%0t %s: got %0h, expected %0h", $time, name, actual, expected);
			abort_run();
		end
	endtask

	// half-period in ticks, C4 up to C5
	function automatic logic [15:0] half_period_of(input logic [2:0] idx);
		case (idx)
			3'd0: return 16'd1911;
			3'd1: return 16'd1702;
			3'd2: return 16'd1516;
			3'd3: return 16'd1431;
			3'd4: return 16'd1275;
			3'd5: return 16'd1136;
			3'd6: return 16'd1012;
			default: return 16'd955;
		endcase
	endfunction

	// falling loudness
	function automatic logic [7:0] level_of(input logic [2:0] idx);
		case (idx)
			3'd0: return 8'hFF;
			3'd1: return 8'hCC;
			3'd2: return 8'hAA;
			3'd3: return 8'h88;
			3'd4: return 8'h66;
			3'd5: return 8'h44;
			3'd6: return 8'h22;
			default: return 8'h0B;
		endcase
	endfunction

	// ------------------------------
	// input file
	// ------------------------------
	task automatic load_accesses();
		int         fd;
		int         fields;
		string      line;
		logic [7:0] op;
		logic [7:0] space;
		logic [15:0] address;
		logic [7:0] data;
		logic [7:0] dip;
		fd = $fopen("tb/bus_test_input.txt", "r");
		if (fd == 0) begin
			$display("cannot open tb/bus_test_input.txt for reading");
			abort_run();
		end else begin
			while ($fgets(line, fd) != 0) begin
				// skip comment and blank lines
				if (line.len() > 1 && line.getc(0) != 8'h23) begin
					fields = $sscanf(line, "%c %c %h %h %h", op, space, address, data, dip);
					if (fields != 5 || !(op == "W" || op == "R") ||
						!(space == "I" || space == "M")) begin
						$display("malformed line in input file: %s", line);
						abort_run();
					end else begin
						accesses.push_back('{op, space, address, data, dip});
					end
				end
			end
			$fclose(fd);
			// 8 cycles per access, plus the sound window
			timeout_limit = accesses.size() * 8 + 3000;
		end
	endtask

	// ------------------------------
	// bus accesses
	// ------------------------------

	// strobe held 3 cycles, released 3
	task automatic drive_access(input access_t acc);
		cart_pkg::bus_req_t req;
		logic               is_read;
		logic               exp_claim;
		logic               exp_oe;
		logic               oe_now;
		is_read = (acc.op == "R");
		// io decode sees the low byte only
		if (acc.space == "I") begin
			exp_claim = (acc.address[7:0] == 8'h01);
		end else begin
			exp_claim = (acc.address == 16'h8001);
		end
		exp_oe = is_read & exp_claim & acc.dip[7];
		req = '0;
		req.address    = acc.address;
		// high byte of an io address aliases the memory port address
		if (acc.space == "I") begin
			req.address[15:8] = 8'h80;
		end
		req.write_data = is_read ? 8'h00 : acc.data;
		req.read       = is_read;
		req.write      = ~is_read;
		req.io         = (acc.space == "I");
		req.memory     = (acc.space == "M");
		for (int c = 0; c < 6; c++) begin
			@(posedge clk);
			if (c == 0) begin
				bus_req <= req;
				dip_sw  <= acc.dip;
			end else if (c == 3) begin
				bus_req <= '0;
			end
			@(negedge clk);
			// write lands on the edge that first sees the strobe
			if (c == 1 && !is_read && exp_claim) begin
				if (acc.space == "I") begin
					exp_io_gpo = acc.data;
				end else begin
					exp_n_led = acc.data[5:0];
				end
			end
			check_equal("bus_claim", 32'(bus_claim), 32'((c < 3) ? exp_claim : 1'b0));
			// driven 2 cycles after read rises, low 1 cycle after it falls
			oe_now = (c == 2 || c == 3) ? exp_oe : 1'b0;
			check_equal("data_oe", 32'(data_oe), 32'(oe_now));
			if (oe_now) begin
				check_equal("read_data", 32'(read_data), 32'(acc.data));
			end
			check_equal("io_gpo", 32'(io_gpo), 32'(exp_io_gpo));
			check_equal("n_led", 32'(n_led), 32'(exp_n_led));
		end
	endtask

	task automatic replay_accesses();
		@(negedge clk);
		// reset values
		check_equal("data_oe", 32'(data_oe), 32'(1'b0));
		check_equal("read_data", 32'(read_data), 32'(8'h00));
		check_equal("io_gpo", 32'(io_gpo), 32'(8'h00));
		check_equal("n_led", 32'(n_led), 32'(6'h00));
		foreach (accesses[i]) begin
			drive_access(accesses[i]);
		end
	endtask

	// ------------------------------
	// sound model
	// ------------------------------
	task automatic model_sound();
		logic [6:0]  m_tick_count;
		logic [15:0] m_div;
		logic [15:0] m_half;
		logic [7:0]  m_level;
		logic [7:0]  m_sample;
		logic [16:0] m_note_count;
		logic [2:0]  m_idx;
		logic [7:0]  m_acc;
		logic        m_sound;
		logic        m_tick;
		logic [7:0]  old_sample;
		logic [8:0]  sum;
		int          ticks;
		m_tick_count = 7'd0;
		m_div        = 16'd0;
		m_half       = 16'd0;
		m_level      = 8'hFF;
		m_sample     = 8'h00;
		m_note_count = 17'd20;
		m_idx        = 3'd0;
		m_acc        = 8'h00;
		m_sound      = 1'b0;
		ticks        = 0;
		while (ticks < 40) begin
			@(posedge clk);
			m_tick       = (m_tick_count == 7'd0);
			m_tick_count = m_tick ? 7'd63 : m_tick_count - 7'd1;
			if (m_tick) begin
				old_sample = m_sample;
				// divider sees period and level from before this tick
				if (m_div == 16'd0) begin
					m_div    = m_half;
					m_sample = (old_sample != 8'h00) ? 8'h00 : m_level;
				end else begin
					m_div = m_div - 16'd1;
				end
				if (m_note_count == 17'd0) begin
					m_note_count = 17'd20;
					m_half       = half_period_of(m_idx);
					m_level      = level_of(m_idx);
					m_idx        = m_idx + 3'd1;
				end else begin
					m_note_count = m_note_count - 17'd1;
				end
				// accumulator takes the sample held before the edge
				sum     = {1'b0, m_acc} + {1'b0, old_sample};
				m_acc   = sum[7:0];
				m_sound = sum[8];
			end
			@(negedge clk);
			if (m_tick) begin
				check_equal("sound", 32'(sound), 32'(m_sound));
				ticks++;
			end
		end
	endtask

	// ------------------------------
	// main sequence
	// ------------------------------
	initial begin
		w_n_reset <= 1'b0;
		bus_req   <= '0;
		dip_sw    <= 8'h00;
		exp_io_gpo = 8'h00;
		exp_n_led  = 6'h00;
		load_accesses();
		repeat (10) @(posedge clk);
		w_n_reset <= 1'b1;
		// sound runs beside the bus traffic
		fork
			model_sound();
			replay_accesses();
		join
		$display("PASS: all tests");
		$finish;
	end

endmodule
